/* list.f */
src/phold_pkg.sv
src/entry_fifo.sv
src/history_access.sv
src/history_filter.sv
src/core_control.sv
src/message_sender.sv
src/phold_core.sv
tests/phold_core_props.sv
tests/phold_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f list.f --top-module phold_core_tb -o phold_sim

./obj_dir/phold_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished without failure"

/* src/core_control.sv */
module core_control (
   input  logic                             clk,
   input  logic                             arst_n,
   input  logic                             event_valid,
   input  phold_pkg::event_msg_t            event_in,
   input  logic [phold_pkg::time_bits-1:0]  gvt,
   input  logic [phold_pkg::rnd_bits-1:0]   random_in,
   output logic                             ready,
   output phold_pkg::event_ctx_t            ctx,
   output logic                             hist_read_start,
   output logic                             hist_write_start,
   input  logic                             hist_done,
   input  logic                             discard_cur,
   output logic                             new_entry_valid,
   output phold_pkg::hist_entry_t           new_entry,
   output phold_pkg::event_msg_t            new_event,
   output logic                             send_start,
   input  logic                             send_done,
   output logic                             idle
);

   phold_pkg::core_state_t            state;
   logic [3:0]                        delay_cnt;
   logic [phold_pkg::time_bits-1:0]   jitter;
   logic [phold_pkg::time_bits-1:0]   gap;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state            <= phold_pkg::st_idle;
         delay_cnt        <= '0;
         hist_read_start  <= 1'b0;
         hist_write_start <= 1'b0;
         send_start       <= 1'b0;
      end else begin
         hist_read_start  <= 1'b0;
         hist_write_start <= 1'b0;
         send_start       <= 1'b0;
         case (state)
            phold_pkg::st_idle: if (event_valid) begin
               hist_read_start <= 1'b1;
               state           <= phold_pkg::st_read;
            end
            phold_pkg::st_read: if (hist_done) begin
               delay_cnt <= '0;
               state     <= phold_pkg::st_delay;
            end
            // random processing time from rnd[19:16]
            phold_pkg::st_delay: begin
               if (delay_cnt == ctx.rnd[19:16])
                  state <= phold_pkg::st_gen;
               else
                  delay_cnt <= delay_cnt + 1'b1;
            end
            phold_pkg::st_gen: begin
               hist_write_start <= 1'b1;
               state            <= phold_pkg::st_write;
            end
            phold_pkg::st_write: if (hist_done) begin
               send_start <= 1'b1;
               state      <= phold_pkg::st_send;
            end
            phold_pkg::st_send: if (send_done)
               state <= phold_pkg::st_idle;
            default: state <= phold_pkg::st_idle;
         endcase
      end
   end

   // context of the event in hand
   always_ff @(posedge clk) begin
      if (event_valid && ready) begin
         ctx.lp   <= event_in.target;
         ctx.ts   <= event_in.ts;
         ctx.kind <= event_in.kind;
         ctx.gvt  <= gvt;
         ctx.rnd  <= random_in;
      end
   end

   always_comb begin
      jitter = '0;
      jitter[5:0] = ctx.rnd[5:0];
      new_event        = '0;
      new_event.kind   = phold_pkg::evt_regular;
      new_event.target = ctx.rnd[10:8];
      new_event.ts     = ctx.ts + phold_pkg::min_gap + jitter;
      gap = new_event.ts - ctx.ts;
      new_entry        = '0;
      new_entry.target = new_event.target;
      new_entry.offset = gap[phold_pkg::offset_bits-1:0];
      new_entry.kind   = ctx.kind;
      new_entry.ts     = ctx.ts;
   end

   // annihilated events leave no trace in the history
   assign new_entry_valid = (state == phold_pkg::st_gen) && !discard_cur;
   assign idle            = (state == phold_pkg::st_idle);
   assign ready           = idle;

endmodule

/* src/entry_fifo.sv */
module entry_fifo #(
   parameter int fifo_depth = 16
) (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic                            clear,
   input  logic                            push,
   input  phold_pkg::hist_entry_t          din,
   input  logic                            pop,
   output phold_pkg::hist_entry_t          head,
   output logic                            empty,
   output logic [$clog2(fifo_depth+1)-1:0] count
);

   localparam int ptr_bits = $clog2(fifo_depth);
   localparam logic [ptr_bits-1:0] last_slot = ptr_bits'(fifo_depth - 1);

   phold_pkg::hist_entry_t mem [fifo_depth];
   logic [ptr_bits-1:0]    wr_ptr;
   logic [ptr_bits-1:0]    rd_ptr;
   logic                   do_push;
   logic                   do_pop;

   // full fifo drops the push, empty ignores the pop
   assign do_push = push && (count != ($clog2(fifo_depth+1))'(fifo_depth));
   assign do_pop  = pop && !empty;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push && !clear)
         mem[wr_ptr] <= din;
   end

   // fall-through head
   assign head  = mem[rd_ptr];
   assign empty = (count == '0);

endmodule

/* src/history_access.sv */
module history_access #(
   parameter int slots_per_lp = 16
) (
   input  logic                                           clk,
   input  logic                                           arst_n,
   input  phold_pkg::event_ctx_t                          ctx,
   input  logic                                           read_start,
   input  logic                                           write_start,
   input  logic [phold_pkg::hist_depth_bits:0]            hist_count,
   input  logic [phold_pkg::hist_depth_bits:0]            retain_count,
   input  phold_pkg::hist_entry_t                         retain_head,
   output logic                                           retain_pop,
   output logic                                           done,
   output phold_pkg::hist_entry_t                         rd_entry,
   output logic                                           rd_valid,
   output logic                                           hist_req,
   output logic                                           hist_we,
   output logic [phold_pkg::lp_bits+phold_pkg::hist_depth_bits-1:0] hist_addr,
   output phold_pkg::hist_entry_t                         hist_wdata,
   input  phold_pkg::hist_entry_t                         hist_rdata,
   input  logic                                           hist_grant
);

   localparam int addr_bits = phold_pkg::lp_bits + phold_pkg::hist_depth_bits;
   localparam int cnt_bits  = phold_pkg::hist_depth_bits + 1;
   localparam logic [addr_bits-1:0] slot_stride = addr_bits'(slots_per_lp);

   logic                 busy;
   logic                 writing;
   logic [cnt_bits-1:0]  idx;
   logic [cnt_bits-1:0]  total;
   logic [cnt_bits-1:0]  start_total;
   logic [addr_bits-1:0] lp_ext;
   logic [addr_bits-1:0] idx_ext;

   assign start_total = read_start ? hist_count : retain_count;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy     <= 1'b0;
         writing  <= 1'b0;
         idx      <= '0;
         total    <= '0;
         hist_req <= 1'b0;
         hist_we  <= 1'b0;
         done     <= 1'b0;
         rd_valid <= 1'b0;
      end else begin
         done     <= 1'b0;
         rd_valid <= 1'b0;
         if (!busy) begin
            if (read_start || write_start) begin
               writing <= write_start;
               total   <= start_total;
               idx     <= '0;
               // nothing to transfer
               if (start_total == '0)
                  done <= 1'b1;
               else
                  busy <= 1'b1;
            end
         end else if (!hist_req) begin
            hist_req <= 1'b1;
            hist_we  <= writing;
         end else if (hist_grant) begin
            hist_req <= 1'b0;
            hist_we  <= 1'b0;
            rd_valid <= !writing;
            idx      <= idx + 1'b1;
            if (idx == total - 1'b1) begin
               busy <= 1'b0;
               done <= 1'b1;
            end
         end
      end
   end

   // read data is only sampled in the grant cycle
   always_ff @(posedge clk) begin
      if (hist_req && hist_grant && !hist_we)
         rd_entry <= hist_rdata;
   end

   // slot address stays put until the grant moves idx on
   always_comb begin
      lp_ext  = '0;
      idx_ext = '0;
      lp_ext[phold_pkg::lp_bits-1:0] = ctx.lp;
      idx_ext[cnt_bits-1:0]          = idx;
      hist_addr = lp_ext * slot_stride + idx_ext;
   end

   assign hist_wdata = retain_head;
   assign retain_pop = hist_req && hist_we && hist_grant;

endmodule

/* src/history_filter.sv */
module history_filter (
   input  logic                      clk,
   input  logic                      arst_n,
   input  phold_pkg::event_ctx_t     ctx,
   input  logic                      idle,
   input  phold_pkg::hist_entry_t    rd_entry,
   input  logic                      rd_valid,
   output logic                      retain_push,
   output logic                      rollback_push,
   output phold_pkg::filter_flags_t  flags
);

   logic                              expired;
   logic                              match;
   logic                              rollback;
   logic [phold_pkg::time_bits-1:0]   offset_ext;
   phold_pkg::event_msg_t             cancel_msg;

   // classification of the entry on the read strobe, first rule wins
   assign expired  = rd_entry.ts < ctx.gvt;
   assign match    = !expired && !flags.match_found &&
                     (rd_entry.kind != ctx.kind) && (rd_entry.ts == ctx.ts);
   assign rollback = !expired && !match &&
                     (ctx.kind == phold_pkg::evt_regular) &&
                     (rd_entry.kind == phold_pkg::evt_regular) &&
                     (rd_entry.ts > ctx.ts);

   assign retain_push   = rd_valid && !expired && !match && !rollback;
   assign rollback_push = rd_valid && rollback;

   // cancellation of whatever the annihilated entry had sent
   always_comb begin
      offset_ext = '0;
      offset_ext[phold_pkg::offset_bits-1:0] = rd_entry.offset;
      cancel_msg        = '0;
      cancel_msg.kind   = phold_pkg::evt_cancel;
      cancel_msg.target = rd_entry.target;
      cancel_msg.ts     = rd_entry.ts + offset_ext;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         flags <= '0;
      end else if (idle) begin
         flags <= '0;
      end else if (rd_valid && match) begin
         flags.match_found <= 1'b1;
         flags.discard_cur <= 1'b1;
         if (ctx.kind == phold_pkg::evt_cancel) begin
            flags.gen_cancel <= 1'b1;
            flags.cancel_msg <= cancel_msg;
         end
      end
   end

endmodule

/* src/message_sender.sv */
module message_sender (
   input  logic                      clk,
   input  logic                      arst_n,
   input  phold_pkg::event_ctx_t     ctx,
   input  logic                      send_start,
   input  phold_pkg::event_msg_t     new_event,
   input  phold_pkg::filter_flags_t  flags,
   input  phold_pkg::hist_entry_t    rb_head,
   input  logic                      rb_empty,
   output logic                      rb_pop,
   output logic                      msg_valid,
   output phold_pkg::event_msg_t     msg_out,
   input  logic                      ack,
   output logic                      send_done
);

   phold_pkg::event_msg_t            first_msg;
   phold_pkg::event_msg_t            rb_cancel;
   phold_pkg::event_msg_t            rb_reexec;
   logic [phold_pkg::time_bits-1:0]  offset_ext;
   logic                             showing_cancel;

   always_comb begin
      if (flags.discard_cur)
         first_msg = flags.gen_cancel ? flags.cancel_msg : phold_pkg::null_msg;
      else if (ctx.kind == phold_pkg::evt_cancel)
         first_msg = phold_pkg::null_msg;
      else
         first_msg = new_event;
   end

   // cancel/re-execute pair for the rollback head
   always_comb begin
      offset_ext = '0;
      offset_ext[phold_pkg::offset_bits-1:0] = rb_head.offset;
      rb_cancel        = '0;
      rb_cancel.kind   = phold_pkg::evt_cancel;
      rb_cancel.target = rb_head.target;
      rb_cancel.ts     = rb_head.ts + offset_ext;
      rb_reexec        = '0;
      rb_reexec.kind   = phold_pkg::evt_regular;
      rb_reexec.target = ctx.lp;
      rb_reexec.ts     = rb_head.ts;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         msg_valid      <= 1'b0;
         showing_cancel <= 1'b0;
         send_done      <= 1'b0;
      end else begin
         send_done <= 1'b0;
         if (send_start) begin
            msg_valid      <= 1'b1;
            showing_cancel <= 1'b0;
         end else if (msg_valid && ack) begin
            if (showing_cancel) begin
               showing_cancel <= 1'b0;
            end else if (rb_empty) begin
               msg_valid <= 1'b0;
               send_done <= 1'b1;
            end else begin
               showing_cancel <= 1'b1;
            end
         end
      end
   end

   // message word changes only on start or after an ack
   always_ff @(posedge clk) begin
      if (send_start)
         msg_out <= first_msg;
      else if (msg_valid && ack && showing_cancel)
         msg_out <= rb_reexec;
      else if (msg_valid && ack && !rb_empty)
         msg_out <= rb_cancel;
   end

   // head is consumed once its re-execute message is loaded
   assign rb_pop = msg_valid && ack && showing_cancel;

endmodule

/* src/phold_core.sv */
module phold_core #(
   parameter int fifo_depth   = 16,
   parameter int slots_per_lp = 16
) (
   input  logic                                           clk,
   input  logic                                           arst_n,
   input  logic                                           event_valid,
   input  phold_pkg::event_msg_t                          event_in,
   input  logic [phold_pkg::time_bits-1:0]                gvt,
   input  logic [phold_pkg::rnd_bits-1:0]                 random_in,
   output logic                                           ready,
   output logic                                           msg_valid,
   output phold_pkg::event_msg_t                          msg_out,
   input  logic                                           ack,
   output logic                                           hist_req,
   output logic                                           hist_we,
   output logic [phold_pkg::lp_bits+phold_pkg::hist_depth_bits-1:0] hist_addr,
   output phold_pkg::hist_entry_t                         hist_wdata,
   input  phold_pkg::hist_entry_t                         hist_rdata,
   input  logic                                           hist_grant,
   input  logic [phold_pkg::hist_depth_bits:0]            hist_count
);

   phold_pkg::event_ctx_t           ctx;
   phold_pkg::filter_flags_t        flags;
   phold_pkg::hist_entry_t          new_entry;
   phold_pkg::hist_entry_t          rd_entry;
   phold_pkg::hist_entry_t          retain_din;
   phold_pkg::hist_entry_t          retain_head;
   phold_pkg::hist_entry_t          rollback_head;
   phold_pkg::event_msg_t           new_event;
   logic                            read_start;
   logic                            write_start;
   logic                            hist_done;
   logic                            new_entry_valid;
   logic                            send_start;
   logic                            send_done;
   logic                            idle;
   logic                            rd_valid;
   logic                            retain_push;
   logic                            rollback_push;
   logic                            retain_pop;
   logic                            rollback_pop;
   logic                            rollback_empty;
   logic [$clog2(fifo_depth+1)-1:0] retain_count;

   // filter and controller never push in the same cycle
   assign retain_din = new_entry_valid ? new_entry : rd_entry;

   core_control u_control (
      .clk, .arst_n, .event_valid, .event_in, .gvt, .random_in, .ready, .ctx,
      .hist_read_start (read_start),
      .hist_write_start(write_start),
      .hist_done,
      .discard_cur     (flags.discard_cur),
      .new_entry_valid, .new_entry, .new_event, .send_start, .send_done, .idle
   );

   history_access #(.slots_per_lp(slots_per_lp)) u_access (
      .clk, .arst_n, .ctx, .read_start, .write_start, .hist_count, .retain_count,
      .retain_head, .retain_pop,
      .done(hist_done),
      .rd_entry, .rd_valid, .hist_req, .hist_we, .hist_addr, .hist_wdata,
      .hist_rdata, .hist_grant
   );

   history_filter u_filter (
      .clk, .arst_n, .ctx, .idle, .rd_entry, .rd_valid, .retain_push,
      .rollback_push, .flags
   );

   entry_fifo #(.fifo_depth(fifo_depth)) retain_fifo (
      .clk, .arst_n,
      .clear(idle),
      .push (retain_push || new_entry_valid),
      .din  (retain_din),
      .pop  (retain_pop),
      .head (retain_head),
      .empty(),
      .count(retain_count)
   );

   entry_fifo #(.fifo_depth(fifo_depth)) rollback_fifo (
      .clk, .arst_n,
      .clear(idle),
      .push (rollback_push),
      .din  (rd_entry),
      .pop  (rollback_pop),
      .head (rollback_head),
      .empty(rollback_empty),
      .count()
   );

   message_sender u_sender (
      .clk, .arst_n, .ctx, .send_start, .new_event, .flags,
      .rb_head (rollback_head),
      .rb_empty(rollback_empty),
      .rb_pop  (rollback_pop),
      .msg_valid, .msg_out, .ack, .send_done
   );

endmodule

/* src/phold_pkg.sv */
package phold_pkg;

   localparam int lp_bits         = 3;
   localparam int time_bits       = 16;
   localparam int rnd_bits        = 24;
   localparam int msg_bits        = 32;
   localparam int hist_depth_bits = 4;
   localparam int offset_bits     = 8;

   // spacing kept between an event and the one it creates
   localparam logic [time_bits-1:0] min_gap = 10;

   typedef enum logic {
      evt_regular = 1'b0,
      evt_cancel  = 1'b1
   } evt_kind_t;

   typedef struct packed {
      logic [msg_bits-time_bits-lp_bits-2:0] pad;
      evt_kind_t                             kind;
      logic [lp_bits-1:0]                    target;
      logic [time_bits-1:0]                  ts;
   } event_msg_t;

   // offset is the distance from the entry time to the event it created
   typedef struct packed {
      logic [msg_bits-time_bits-offset_bits-lp_bits-2:0] pad;
      logic [lp_bits-1:0]                                target;
      logic [offset_bits-1:0]                            offset;
      evt_kind_t                                         kind;
      logic [time_bits-1:0]                              ts;
   } hist_entry_t;

   typedef struct packed {
      logic [lp_bits-1:0]   lp;
      logic [time_bits-1:0] ts;
      evt_kind_t            kind;
      logic [time_bits-1:0] gvt;
      logic [rnd_bits-1:0]  rnd;
   } event_ctx_t;

   typedef struct packed {
      logic       discard_cur;
      logic       gen_cancel;
      logic       match_found;
      event_msg_t cancel_msg;
   } filter_flags_t;

   typedef enum logic [2:0] {
      st_idle, st_read, st_delay, st_gen, st_write, st_send
   } core_state_t;

   // sent in place of a new event when nothing is generated
   localparam event_msg_t null_msg = '{pad: '0, kind: evt_cancel, target: '0, ts: '0};

endpackage

/* tests/phold_core_props.sv */
module phold_core_props (
   input logic                                                  clk,
   input logic                                                  arst_n,
   input logic                                                  ready,
   input logic                                                  msg_valid,
   input phold_pkg::event_msg_t                                 msg_out,
   input logic                                                  ack,
   input logic                                                  hist_req,
   input logic                                                  hist_we,
   input logic [phold_pkg::lp_bits+phold_pkg::hist_depth_bits-1:0] hist_addr,
   input logic                                                  hist_grant
);
   timeunit 1ns;
   timeprecision 1ps;

   // message held until acknowledged
   msg_hold: assert property (@(posedge clk) disable iff (!arst_n)
      msg_valid && !ack |=> msg_valid && $stable(msg_out))
      else $error("msg_out or msg_valid changed while waiting for ack");

   // history request held until granted
   hist_hold: assert property (@(posedge clk) disable iff (!arst_n)
      hist_req && !hist_grant |=> hist_req && $stable(hist_addr) && $stable(hist_we))
      else $error("history request changed while waiting for grant");

   idle_not_sending: assert property (@(posedge clk) disable iff (!arst_n)
      !(ready && msg_valid))
      else $error("ready and msg_valid high in the same cycle");

endmodule

bind phold_core phold_core_props u_props (
   .clk       (clk),
   .arst_n    (arst_n),
   .ready     (ready),
   .msg_valid (msg_valid),
   .msg_out   (msg_out),
   .ack       (ack),
   .hist_req  (hist_req),
   .hist_we   (hist_we),
   .hist_addr (hist_addr),
   .hist_grant(hist_grant)
);

/* tests/phold_core_tb.sv */
module phold_core_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int depth_bits       = phold_pkg::hist_depth_bits;
   localparam int cnt_bits         = depth_bits + 1;
   localparam int addr_bits        = phold_pkg::lp_bits + depth_bits;
   localparam int max_events       = 16;
   localparam int cols             = 12;
   localparam int max_msgs         = 6;
   localparam int cycles_per_event = 400;
   localparam logic [31:0] seed    = 32'h0d78_75a1;

   logic                             clk;
   logic                             arst_n;
   logic                             event_valid;
   phold_pkg::event_msg_t            event_in;
   logic [phold_pkg::time_bits-1:0]  gvt;
   logic [phold_pkg::rnd_bits-1:0]   random_in;
   logic                             ready;
   logic                             msg_valid;
   phold_pkg::event_msg_t            msg_out;
   logic                             ack;
   logic                             hist_req;
   logic                             hist_we;
   logic [addr_bits-1:0]             hist_addr;
   phold_pkg::hist_entry_t           hist_wdata;
   phold_pkg::hist_entry_t           hist_rdata;
   logic                             hist_grant;
   logic [cnt_bits-1:0]              hist_count;

   logic [31:0]            golden [max_events*cols];
   phold_pkg::hist_entry_t hist_mem [1 << addr_bits];
   logic [cnt_bits-1:0]    hist_cnt [1 << phold_pkg::lp_bits];
   logic [31:0]            got_msgs [$];
   logic [31:0]            lcg_state;
   logic [phold_pkg::lp_bits-1:0] cur_lp;
   int read_count;
   int write_count;
   int value_errors;
   int other_errors;
   int cycle_count;
   int cycle_limit;
   int num_events;

   phold_core #(.fifo_depth(16), .slots_per_lp(16)) dut (.*);

   always #50 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         value_errors++;
         $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic note_failure(input string what);
      other_errors++;
      $display("%s at %0t", what, $time);
   endtask

   task automatic print_counts();
      $display("errors: %0d value mismatches, %0d other failures", value_errors,
               other_errors);
   endtask

   // history memory and message sink, both paced by the lcg
   initial begin : mem_model
      logic [addr_bits-1:0] addr_exp;
      ack        = 1'b0;
      hist_grant = 1'b0;
      hist_rdata = '0;
      lcg_state  = seed;
      forever begin
         @(negedge clk);
         if (ack) begin
            ack = 1'b0;
         end else if (msg_valid) begin
            lcg_state = lcg_next(lcg_state);
            if (lcg_state[31:30] != 2'b00) begin
               ack = 1'b1;
               got_msgs.push_back(msg_out);
            end
         end
         if (hist_grant) begin
            hist_grant = 1'b0;
         end else if (hist_req) begin
            lcg_state = lcg_next(lcg_state);
            if (lcg_state[31:29] < 3'd3) begin
               // slots are walked from the start of the LP's block
               addr_exp = {cur_lp, depth_bits'(hist_we ? write_count : read_count)};
               check_value("hist_addr", 32'(hist_addr), 32'(addr_exp));
               hist_grant = 1'b1;
               hist_rdata = hist_mem[hist_addr];
               if (hist_we) begin
                  hist_mem[hist_addr] = hist_wdata;
                  write_count++;
               end else begin
                  read_count++;
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      if (!arst_n)
         cycle_count <= 0;
      else
         cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
         $display("timeout, core did not finish within %0d cycles", cycle_limit);
         print_counts();
         $display("TEST FAIL");
         $finish;
      end
   end

   task automatic run_event(input int e);
      int base;
      int n_exp;
      int hcnt_exp;
      int reads_exp;
      phold_pkg::event_msg_t ev;
      logic [addr_bits-1:0] last_slot;
      base     = e * cols;
      ev       = golden[base];
      n_exp    = int'(golden[base+3]);
      hcnt_exp = int'(golden[base+4]);
      if (n_exp > max_msgs)
         note_failure($sformatf("golden row %0d lists too many messages", e));
      reads_exp   = int'(hist_cnt[ev.target]);
      cur_lp      = ev.target;
      hist_count  = hist_cnt[ev.target];
      read_count  = 0;
      write_count = 0;
      got_msgs.delete();
      event_in    = ev;
      gvt         = golden[base+1][phold_pkg::time_bits-1:0];
      random_in   = golden[base+2][phold_pkg::rnd_bits-1:0];
      event_valid = 1'b1;
      @(negedge clk);
      event_valid = 1'b0;
      // the core leaves idle once the event is taken
      check_value("ready", 32'(ready), 32'd0);
      while (!ready)
         @(negedge clk);
      // the memory keeps what was written back
      hist_cnt[ev.target] = cnt_bits'(write_count);
      check_value("hist_req reads", read_count, reads_exp);
      check_value("msg_out count", got_msgs.size(), n_exp);
      for (int i = 0; i < n_exp && i < got_msgs.size(); i++)
         check_value($sformatf("msg_out[%0d] of event %0d", i, e), got_msgs[i],
                     golden[base+6+i]);
      check_value("hist_count", 32'(hist_cnt[ev.target]), golden[base+4]);
      if (hcnt_exp != 0) begin
         last_slot = {ev.target, depth_bits'(hcnt_exp - 1)};
         check_value("hist_wdata", hist_mem[last_slot], golden[base+5]);
      end
   endtask

   initial begin
      clk         = 1'b0;
      arst_n      = 1'b0;
      event_valid = 1'b0;
      event_in    = '0;
      gvt         = '0;
      random_in   = '0;
      hist_count  = '0;
      cur_lp      = '0;
      for (int a = 0; a < (1 << addr_bits); a++)
         hist_mem[a] = 32'h5a00_0000 ^ (32'(a) * 32'h0001_0101);
      for (int l = 0; l < (1 << phold_pkg::lp_bits); l++)
         hist_cnt[l] = '0;
      // empty rows keep the all-ones marker
      for (int i = 0; i < max_events * cols; i++)
         golden[i] = '1;
      $readmemh("tests/phold_golden.txt", golden);
      num_events = 0;
      while (num_events < max_events && golden[num_events*cols] != '1)
         num_events++;
      if (num_events == 0)
         note_failure("golden file holds no events");
      cycle_limit = (num_events + 1) * cycles_per_event;

      repeat (3) @(negedge clk);
      arst_n = 1'b1;
      check_value("ready", 32'(ready), 32'd1);
      check_value("msg_valid", 32'(msg_valid), 32'd0);
      check_value("hist_req", 32'(hist_req), 32'd0);
      check_value("hist_we", 32'(hist_we), 32'd0);

      for (int e = 0; e < num_events; e++)
         run_event(e);

      repeat (2) @(negedge clk);
      print_counts();
      if (value_errors == 0 && other_errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

/* tests/phold_golden.txt */
// event gvt random n_msgs hist_count last_entry msg0 msg1 msg2 msg3 msg4 msg5
// hist_count and last_entry give the target LP history after the event
00020064 0000 020305 1 1 061E0064 00030073 0 0 0 0 0
000200C8 0032 00050A 1 2 0A2800C8 000500DC 0 0 0 0 0
0002012C 0096 0F073F 1 2 0E92012C 00070175 0 0 0 0 0
000200BE 0096 030100 5 1 021400BE 000100C8 000D00DC 000200C8 000F0175 0002012C 0
000A00BE 0096 010402 1 0 0 000900C8 0 0 0 0 0
000C0200 0096 020601 1 1 0C170200 00080000 0 0 0 0 0
00040200 0096 000203 1 0 0 00080000 0 0 0 0 0
00000300 00C8 050420 1 1 08540300 0004032A 0 0 0 0 0
00000310 00C8 010001 1 2 00160310 0000031B 0 0 0 0 0
00000308 00C8 000702 3 2 0E180308 00070314 0008031B 00000310 0 0 0
00000400 0320 020200 1 1 04140400 0002040A 0 0 0 0 0
00080400 0320 000000 1 0 0 000A040A 0 0 0 0 0
000D0500 0320 000304 1 1 061D0500 00080000 0 0 0 0 0
00050400 0320 010105 1 2 021E0400 0001040F 0 0 0 0 0
00050380 0320 04063F 3 2 0C920380 000603C9 0009040F 00050400 0 0 0
